// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/core_ctrl_pkg.sv
  - hdl/control.sv
  - hdl/imm_gen.sv
  - hdl/alu.sv
  - hdl/regfile.sv
  - hdl/data_mem.sv
  - hdl/core_top.sv
  - target: simulation
    files:
      - bench/core_sva.sv
      - bench/core_tb.sv

// ==== bench/core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_sva import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            setup,
    input logic [xlen-1:0] pc,
    input commit_t         commit,
    input logic [xlen-1:0] rf_regs [32]
);

    int sva_errors = 0; // Read by the testbench

    // Committed value lands in the register file
    commit_written: assert property (@(posedge clk) disable iff (rst)
        commit.valid |=> rf_regs[$past(commit.rd)] == $past(commit.data))
        else begin
            $error("committed value not found in the register file");
            sva_errors++;
        end

    no_commit_in_setup: assert property (@(posedge clk) disable iff (rst)
        setup |-> !commit.valid)
        else begin
            $error("commit while setup is high");
            sva_errors++;
        end

    pc_word_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else begin
            $error("PC not word aligned: %h", pc);
            sva_errors++;
        end

endmodule

bind core_top core_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .setup   (setup),
    .pc      (pc),
    .commit  (commit),
    .rf_regs (u_regfile.regs)
);

`default_nettype wire

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb import rv_isa_pkg::*, core_ctrl_pkg::*; ();

    localparam int n_tests        = 5;
    localparam int body_len       = 24;
    localparam int max_len        = 80;
    localparam int timeout_cycles = n_tests * (max_len + max_len + 20);

    logic                          clk;
    logic                          rst;
    logic                          setup;
    logic                          load_we;
    logic [$clog2(imem_depth)-1:0] load_addr;
    logic [xlen-1:0]               load_instr;
    commit_t                       commit;

    logic [31:0] rng_state = 32'd78;
    logic [31:0] prog [max_len];
    int          prog_len;
    logic [31:0] mregs [32];  // Model registers
    logic [7:0]  mbytes [64]; // Model data memory, first 64 bytes
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          failed_tests;
    int          checked;
    int          cycle_count;
    string       test_names [n_tests] = '{"alu_ops", "upper_imm", "load_store",
                                          "control_flow", "x0_and_setup"};

    core_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .setup      (setup),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_instr (load_instr),
        .commit     (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run exceeded %0d cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] rand32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + rand32() % 15); // x1 to x15
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opcode_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcode_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
    endfunction

    // Random OP or OP-IMM, shift amounts of 31 favoured
    function automatic logic [31:0] rand_alu(input logic [4:0] rd);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  sh;
        logic [11:0] imm;
        logic [31:0] ins;
        r   = rand32();
        f3  = r[3:1];
        sh  = r[5] ? 5'd31 : r[12:8];
        imm = {{4{r[27]}}, r[27:20]};
        if (f3 == f3_sll) begin
            imm = {7'h00, sh};
        end else if (f3 == f3_srl_sra) begin
            imm = {r[4] ? 7'h20 : 7'h00, sh};
        end
        if (r[0]) begin
            ins = enc_r(((f3 == f3_add_sub || f3 == f3_srl_sra) && r[4]) ? 7'h20 : 7'h00,
                        rand_reg(), rand_reg(), f3, rd, opcode_op);
        end else begin
            ins = enc_i(imm, rand_reg(), f3, rd, opcode_op_imm);
        end
        return ins;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return $signed(a) < $signed(b);
            f3_bge:  return $signed(a) >= $signed(b);
            f3_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    task automatic gen_program(input int mode);
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0]  f3;
        logic [5:0]  ea;
        logic [4:0]  xr;
        int          end_idx;
        int          k;
        prog_len = 0;
        if (mode != 4) begin
            for (int i = 1; i < 16; i++) begin // Random start value in x1 to x15
                v = rand32();
                emit(enc_u(v[31:12], 5'(i), opcode_lui));
                emit(enc_i(v[11:0], 5'(i), f3_add_sub, 5'(i), opcode_op_imm));
            end
        end
        if (mode == 2) begin
            for (int w = 0; w < 16; w++) begin // Fill the 64 bytes under test
                emit(enc_s(12'(w * 4), rand_reg(), 5'd0, f3_sw));
            end
        end
        end_idx = prog_len + body_len;
        while (prog_len < end_idx) begin
            r = rand32();
            k = 1 + r[7:6];
            if (k > end_idx - prog_len) begin
                k = end_idx - prog_len;
            end
            case (mode)
                1: emit(enc_u({{8{r[19]}}, r[19:8]}, rand_reg(),
                              r[0] ? opcode_lui : opcode_auipc));
                2: begin
                    f3 = r[2:0];
                    ea = r[13:8];
                    if (r[3]) begin
                        f3[2] = 1'b0;
                        if (f3[1:0] == 2'b11) begin
                            f3[1:0] = 2'b10;
                        end
                    end else if (f3 == 3'b011) begin
                        f3 = f3_lw;
                    end else if (f3[2:1] == 2'b11) begin
                        f3[1] = 1'b0; // lbu or lhu
                    end
                    if (f3[1:0] != 2'd0) begin
                        ea[0] = 1'b0;
                    end
                    if (f3[1:0] == 2'd2) begin
                        ea[1] = 1'b0;
                    end
                    if (r[3]) begin
                        emit(enc_s({6'd0, ea}, rand_reg(), 5'd0, f3));
                    end else begin
                        emit(enc_i({6'd0, ea}, 5'd0, f3, rand_reg(), opcode_load));
                    end
                end
                3: begin
                    if (r[2:0] < 3'd3) begin
                        f3 = r[10:8];
                        if (f3[2:1] == 2'b01) begin
                            f3[2] = 1'b1; // Map onto a real branch
                        end
                        xr = rand_reg();
                        emit(enc_b(4 * k, r[11] ? xr : rand_reg(), xr, f3));
                    end else if (r[2:0] == 3'd3) begin
                        emit(enc_j(4 * k, rand_reg()));
                    end else if (r[2:0] == 3'd4 && prog_len + 1 < end_idx) begin
                        xr = rand_reg();
                        emit(enc_u(20'd0, xr, opcode_auipc)); // JALR base
                        if (k > end_idx - prog_len) begin
                            k = end_idx - prog_len;
                        end
                        emit(enc_i(12'(4 * k + 4 + r[12]), xr, 3'b000, rand_reg(), opcode_jalr));
                    end else begin
                        emit(rand_alu(rand_reg()));
                    end
                end
                4: emit(rand_alu((prog_len < 3 || r[0]) ? 5'd0 : rand_reg()));
                default: emit(rand_alu(rand_reg()));
            endcase
        end
        emit(enc_j(32'd0, 5'd0)); // Self-loop
    endtask

    // ISA model, fills the expected commit queues
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [31:0] ea;
        logic [31:0] ld;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic        wr;
        logic        done;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < max_len) begin
            ins   = prog[pc >> 2];
            f3    = ins[14:12];
            rd    = ins[11:7];
            a     = mregs[ins[19:15]];
            b     = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            res   = '0;
            nxt   = pc + 4;
            wr    = 1'b1;
            case (ins[6:0])
                opcode_op:     res = alu_ref(f3, ins[30], a, b);
                opcode_op_imm: res = alu_ref(f3, ins[30] && f3 == f3_srl_sra, a, imm_i);
                opcode_lui:    res = {ins[31:12], 12'h000};
                opcode_auipc:  res = pc + {ins[31:12], 12'h000};
                opcode_jal: begin
                    res  = pc + 4;
                    nxt  = pc + imm_j;
                    done = (imm_j == 0);
                end
                opcode_jalr: begin
                    res = pc + 4;
                    nxt = (a + imm_i) & ~32'd1;
                end
                opcode_branch: begin
                    wr = 1'b0;
                    if (branch_ref(f3, a, b)) begin
                        nxt = pc + imm_b;
                    end
                end
                opcode_load: begin
                    ea = a + imm_i;
                    ld = {mbytes[6'(ea + 3)], mbytes[6'(ea + 2)],
                          mbytes[6'(ea + 1)], mbytes[ea[5:0]]};
                    case (f3)
                        f3_lb:   res = {{24{ld[7]}}, ld[7:0]};
                        f3_lh:   res = {{16{ld[15]}}, ld[15:0]};
                        f3_lbu:  res = {24'd0, ld[7:0]};
                        f3_lhu:  res = {16'd0, ld[15:0]};
                        default: res = ld;
                    endcase
                end
                opcode_store: begin
                    wr = 1'b0;
                    ea = a + imm_s;
                    for (int i = 0; i < 4; i++) begin
                        if (i < (1 << f3[1:0])) begin
                            mbytes[6'(ea + i)] = b[8*i +: 8];
                        end
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                mregs[rd] = res;
                exp_pc.push_back(pc);
                exp_rd.push_back(rd);
                exp_data.push_back(res);
            end
            pc = nxt;
            steps++;
        end
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual,
                               inout int errs);
        assert (actual === expected) else begin
            $display("ERR %s %s: expected %h actual %h", test, field, expected, actual);
            errs++;
        end
    endtask

    task automatic run_test(input int mode);
        int errs;
        int commits;
        errs    = 0;
        commits = 0;
        gen_program(mode);
        run_model();
        @(posedge clk);
        #1;
        rst   = 1'b1;
        setup = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            load_we    = 1'b1;
            load_addr  = 8'(i);
            load_instr = prog[i];
            @(negedge clk);
            assert (!commit.valid) else begin
                $display("%s: commit seen while setup is high", test_names[mode]);
                errs++;
            end
            @(posedge clk);
            #1;
        end
        load_we = 1'b0;
        setup   = 1'b0;
        while (exp_pc.size() > 0) begin
            @(negedge clk); // Commit is stable mid-cycle
            if (commit.valid) begin
                check_value(test_names[mode], "pc", exp_pc.pop_front(), commit.pc, errs);
                check_value(test_names[mode], "rd", 32'(exp_rd.pop_front()), 32'(commit.rd),
                            errs);
                check_value(test_names[mode], "data", exp_data.pop_front(), commit.data, errs);
                commits++;
            end
        end
        repeat (4) begin
            @(negedge clk);
            assert (!commit.valid) else begin
                $display("%s: commit after the program reached its final loop",
                         test_names[mode]);
                errs++;
            end
        end
        checked += commits;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("%s: %0d commits checked, %0d errors", test_names[mode], commits, errs);
    endtask

    initial begin
        rst          = 1'b1;
        setup        = 1'b1;
        load_we      = 1'b0;
        load_addr    = '0;
        load_instr   = '0;
        failed_tests = 0;
        checked      = 0;
        for (int i = 0; i < 64; i++) begin
            mbytes[i] = '0;
        end
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d with errors, %0d commits checked, %0d assertion failures",
                 n_tests, failed_tests, checked, u_dut.u_sva.sva_errors);
        if (failed_tests == 0 && u_dut.u_sva.sva_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  alu_op_e         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            taken
);

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << b[4:0];
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_srl:    result = a >> b[4:0];
            alu_sra:    result = $signed(a) >>> b[4:0];
            alu_pass_b: result = b; // LUI
            alu_beq:    taken  = (a == b);
            alu_bne:    taken  = (a != b);
            alu_blt:    taken  = ($signed(a) < $signed(b));
            alu_bge:    taken  = ($signed(a) >= $signed(b));
            alu_bltu:   taken  = (a < b);
            alu_bgeu:   taken  = (a >= b);
            default:    ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic [xlen-1:0] instr,
    output ctrl_t           ctrl
);

    logic [6:0] opcode;
    logic [2:0] f3;
    logic       alt;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign alt    = instr[30]; // Selects sub and sra

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = alu_add;
        ctrl.br_type  = br_none;
        ctrl.mem_size = mem_word;
        ctrl.wb_sel   = wb_none;
        case (opcode)
            opcode_op, opcode_op_imm: begin
                ctrl.reg_we  = 1'b1;
                ctrl.op2_reg = (opcode == opcode_op);
                ctrl.wb_sel  = wb_alu;
                case (f3)
                    f3_add_sub: ctrl.alu_op = (ctrl.op2_reg && alt) ? alu_sub : alu_add;
                    f3_sll:     ctrl.alu_op = alu_sll;
                    f3_slt:     ctrl.alu_op = alu_slt;
                    f3_sltu:    ctrl.alu_op = alu_sltu;
                    f3_xor:     ctrl.alu_op = alu_xor;
                    f3_srl_sra: ctrl.alu_op = alt ? alu_sra : alu_srl;
                    f3_or:      ctrl.alu_op = alu_or;
                    f3_and:     ctrl.alu_op = alu_and;
                endcase
            end
            opcode_lui: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_pass_b;
                ctrl.wb_sel = wb_alu;
            end
            opcode_auipc: begin
                ctrl.reg_we = 1'b1;
                ctrl.op1_pc = 1'b1;
                ctrl.wb_sel = wb_alu;
            end
            opcode_jal: begin
                ctrl.reg_we  = 1'b1;
                ctrl.op1_pc  = 1'b1;
                ctrl.br_type = br_jal;
                ctrl.wb_sel  = wb_ret_addr;
            end
            opcode_jalr: begin
                ctrl.reg_we  = 1'b1;
                ctrl.br_type = br_jalr;
                ctrl.wb_sel  = wb_ret_addr;
            end
            opcode_branch: begin
                ctrl.op2_reg = 1'b1;
                ctrl.br_type = br_branch;
                case (f3)
                    f3_beq:  ctrl.alu_op = alu_beq;
                    f3_bne:  ctrl.alu_op = alu_bne;
                    f3_blt:  ctrl.alu_op = alu_blt;
                    f3_bge:  ctrl.alu_op = alu_bge;
                    f3_bltu: ctrl.alu_op = alu_bltu;
                    f3_bgeu: ctrl.alu_op = alu_bgeu;
                    default: ctrl.br_type = br_none; // Reserved funct3
                endcase
            end
            opcode_load: begin
                ctrl.reg_we       = 1'b1;
                ctrl.mem_re       = 1'b1;
                ctrl.wb_sel       = wb_load;
                ctrl.mem_unsigned = (f3 == f3_lbu) || (f3 == f3_lhu);
                case (f3)
                    f3_lb, f3_lbu: ctrl.mem_size = mem_byte;
                    f3_lh, f3_lhu: ctrl.mem_size = mem_half;
                    f3_lw:         ctrl.mem_size = mem_word;
                    default: begin
                        ctrl.reg_we = 1'b0;
                        ctrl.mem_re = 1'b0;
                    end
                endcase
            end
            opcode_store: begin
                ctrl.mem_we = 1'b1;
                case (f3)
                    f3_sb:   ctrl.mem_size = mem_byte;
                    f3_sh:   ctrl.mem_size = mem_half;
                    f3_sw:   ctrl.mem_size = mem_word;
                    default: ctrl.mem_we = 1'b0;
                endcase
            end
            default: ; // Unsupported, no side effects
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

    localparam int imem_depth = 256; // Words
    localparam int dmem_depth = 256; // Words

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_or, alu_and,
        alu_srl, alu_sra, alu_pass_b,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
    } alu_op_e;

    typedef enum logic [1:0] {br_none, br_branch, br_jal, br_jalr} br_type_e;

    typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_e;

    typedef enum logic [1:0] {wb_none, wb_alu, wb_load, wb_ret_addr} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      reg_we;
        br_type_e  br_type;
        logic      mem_we;
        logic      mem_re;
        mem_size_e mem_size;
        logic      mem_unsigned;
        logic      op1_pc;       // PC instead of rs1
        logic      op2_reg;      // rs2 instead of immediate
        wb_sel_e   wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } commit_t;

endpackage

`default_nettype wire

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          setup,
    input  logic                          load_we,
    input  logic [$clog2(imem_depth)-1:0] load_addr,
    input  logic [xlen-1:0]               load_instr,
    output commit_t                       commit
);

    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] instr;
    logic [4:0]      rd;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;
    logic            taken;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;

    always_ff @(posedge clk) begin
        if (setup && load_we) begin
            imem[load_addr] <= load_instr;
        end
    end

    // NOP while loading so nothing is written
    assign instr = setup ? nop_instr : imem[pc[$clog2(imem_depth)+1:2]];
    assign rd    = instr[11:7];

    always_ff @(posedge clk) begin
        if (rst || setup) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + imm; // Branch and JAL target

    always_comb begin
        case (ctrl.br_type)
            br_jal:    pc_next = br_target;
            br_jalr:   pc_next = {alu_result[xlen-1:1], 1'b0};
            br_branch: pc_next = taken ? br_target : pc_plus4;
            default:   pc_next = pc_plus4;
        endcase
    end

    control u_control (.instr(instr), .ctrl(ctrl));

    imm_gen u_imm_gen (.instr(instr), .imm(imm));

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (ctrl.reg_we),
        .rd       (rd),
        .rd_data  (wb_data)
    );

    assign operand_a = ctrl.op1_pc ? pc : rs1_data;
    assign operand_b = ctrl.op2_reg ? rs2_data : imm;

    alu u_alu (.op(ctrl.alu_op), .a(operand_a), .b(operand_b), .result(alu_result), .taken(taken));

    data_mem u_data_mem (
        .clk           (clk),
        .addr          (alu_result),
        .wdata         (rs2_data),
        .we            (ctrl.mem_we),
        .re            (ctrl.mem_re),
        .size          (ctrl.mem_size),
        .unsigned_load (ctrl.mem_unsigned),
        .rdata         (load_data)
    );

    always_comb begin
        case (ctrl.wb_sel)
            wb_alu:      wb_data = alu_result;
            wb_load:     wb_data = load_data;
            wb_ret_addr: wb_data = pc_plus4; // Link value
            default:     wb_data = '0;
        endcase
    end

    always_comb begin
        commit.valid = ctrl.reg_we && (rd != 5'd0);
        commit.pc    = pc;
        commit.rd    = rd;
        commit.data  = wb_data;
    end

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic            clk,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    input  logic            we,
    input  logic            re,
    input  mem_size_e       size,
    input  logic            unsigned_load,
    output logic [xlen-1:0] rdata
);

    logic [3:0][7:0]               mem [dmem_depth];
    logic [$clog2(dmem_depth)-1:0] idx;
    logic [1:0]                    off;
    logic [3:0]                    be;
    logic [3:0][7:0]               wlanes;
    logic [3:0][7:0]               rword;
    logic [15:0]                   rhalf;
    logic [7:0]                    rbyte;

    assign idx = addr[$clog2(dmem_depth)+1:2];
    assign off = addr[1:0];

    always_comb begin
        case (size)
            mem_byte: begin
                be     = 4'b0001 << off;
                wlanes = {4{wdata[7:0]}};
            end
            mem_half: begin
                be     = 4'b0011 << {off[1], 1'b0};
                wlanes = {2{wdata[15:0]}};
            end
            default: begin
                be     = 4'b1111;
                wlanes = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx][i] <= wlanes[i];
                end
            end
        end
    end

    assign rword = mem[idx];
    assign rhalf = off[1] ? rword[3:2] : rword[1:0];
    assign rbyte = rword[off];

    always_comb begin
        rdata = '0;
        if (re) begin
            case (size)
                mem_byte: rdata = {{24{~unsigned_load & rbyte[7]}}, rbyte};
                mem_half: rdata = {{16{~unsigned_load & rhalf[15]}}, rhalf};
                default:  rdata = rword;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_isa_pkg::*; (
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (instr[6:0])
            opcode_op_imm, opcode_load, opcode_jalr:
                imm = {{20{instr[31]}}, instr[31:20]};
            opcode_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opcode_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            opcode_lui, opcode_auipc:
                imm = {instr[31:12], 12'b0};
            opcode_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            we,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] rd_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 reads zero
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    // Major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== sources.f ====
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/control.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/regfile.sv
hdl/data_mem.sv
hdl/core_top.sv
bench/core_sva.sv
bench/core_tb.sv
